//--- verification/cap_rf_stim.txt
// one record per line, hex: op_addr_arg_par_cap
// op 1 write (arg data, cap written), 2 read (arg, par, cap expected on both ports),
// op 3 reserve (arg ready vector after), 4 revoke (arg clrtag), 5 idle (addr cycles, arg ready)
5_02_ffffffff_00_0000000000
2_03_00000000_75_0000000000
1_01_00000001_00_0000000000
1_02_00000030_00_0000000000
1_05_80000003_00_0000000000
1_1f_0000f000_00_0000000000
1_00_deadbeef_00_2000001234
2_01_00000001_14_0000000000
2_02_00000030_64_0000000000
2_05_80000003_57_0000000000
2_1f_0000f000_7a_0000000000
2_00_00000000_2a_0000000000
// capabilities written with data
1_07_40000000_00_2000001234
1_09_00000002_00_0000250080
2_07_40000000_00_2000001234
2_09_00000002_1a_0000250080
// reservation, then revocation with tag clear, bypass read in the issue cycle
3_07_ffffff7f_00_0000000000
4_07_00000001_00_0000000000
2_07_40000000_00_0000001234
2_07_40000000_15_0000001234
5_02_ffffffff_00_0000000000
// reservation in the issue cycle of a revocation of the same entry
4_02_00000000_00_0000000000
3_02_fffffffb_00_0000000000
4_02_00000000_00_0000000000
5_02_ffffffff_00_0000000000
// burst up to the credit limit
4_01_00000000_00_0000000000
4_05_00000000_00_0000000000
4_09_00000001_00_0000000000
4_1f_00000000_00_0000000000
5_03_ffffffff_00_0000000000
2_09_00000002_0f_0000250080
2_01_00000001_14_0000000000
2_1f_0000f000_7a_0000000000

//--- filelist.f
design/cap_rf_pkg.sv
design/rf_secded_enc.sv
design/rf_secded_dec.sv
design/rvk_req_queue.sv
design/cap_regfile.sv
design/cap_rf_top.sv
verification/tb_clk_gen.sv
verification/cap_rf_tb.sv

//--- verification/cap_rf_tb.sv
`timescale 1ns/1ns
// -------------------------------------------------------------------------
// testbench for the capability register file subsystem: replays the stim
// records and checks words, capabilities, ready vector, credits and alert
// -------------------------------------------------------------------------
module cap_rf_tb import cap_rf_pkg::*; ();

  localparam int STIM_MAX = 64;

  typedef enum logic [3:0] {
    OP_END     = 4'h0,
    OP_WRITE   = 4'h1,
    OP_READ    = 4'h2,
    OP_RESERVE = 4'h3,
    OP_REVOKE  = 4'h4,
    OP_IDLE    = 4'h5
  } stim_op_e;

  // one stim record, 23 hex digits
  typedef struct packed {
    logic [3:0]  op;
    logic [7:0]  addr;
    logic [31:0] arg;
    logic [7:0]  par;
    logic [39:0] cap;
  } stim_rec_t;

  logic [91:0] stim_mem [STIM_MAX];

  logic              clk;
  logic              par_rst_n;
  logic [ADDR_W-1:0] raddr_a, raddr_b, waddr, trsv_addr, rvk_addr;
  logic [DATA_W-1:0] wdata;
  reg_cap_t          wcap;
  logic              we, trsv_valid, rvk_valid, rvk_clrtag;
  rf_word_t          rword_a, rword_b;
  reg_cap_t          rcap_a, rcap_b;
  logic              rvk_credit;
  logic [NREGS-1:0]  reg_rdy;
  logic              alert;

  int   err_cnt       = 0;
  int   check_cnt     = 0;
  int   test_cnt      = 0;
  int   credits       = RVK_DEPTH;
  int   credit_pulses = 0;
  int   rvk_sent      = 0;
  int   cycle_cnt     = 0;
  int   cycle_limit   = 100;
  logic alert_seen    = 1'b0;

  tb_clk_gen clk_gen_i (.clk_o(clk), .rst_no(par_rst_n));

  cap_rf_top cap_rf_top_i (
    .clk_i        (clk),
    .par_rst_ni   (par_rst_n),
    .raddr_a_i    (raddr_a),
    .raddr_b_i    (raddr_b),
    .rword_a_o    (rword_a),
    .rword_b_o    (rword_b),
    .rcap_a_o     (rcap_a),
    .rcap_b_o     (rcap_b),
    .waddr_i      (waddr),
    .wdata_i      (wdata),
    .wcap_i       (wcap),
    .we_i         (we),
    .trsv_valid_i (trsv_valid),
    .trsv_addr_i  (trsv_addr),
    .rvk_valid_i  (rvk_valid),
    .rvk_addr_i   (rvk_addr),
    .rvk_clrtag_i (rvk_clrtag),
    .rvk_credit_o (rvk_credit),
    .reg_rdy_o    (reg_rdy),
    .alert_o      (alert)
  );

  function automatic string op_name(input logic [3:0] op);
    case (op)
      OP_WRITE:   return "write";
      OP_READ:    return "read";
      OP_RESERVE: return "reserve";
      OP_REVOKE:  return "revoke";
      OP_IDLE:    return "idle";
      default:    return "unknown";
    endcase
  endfunction

  task automatic word_check(input string what, input rf_word_t got, input rf_word_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t ns: %s par %h data %h, expected par %h data %h",
               $time, what, got.par, got.data, exp.par, exp.data);
    end
  endtask

  task automatic cap_check(input string what, input reg_cap_t got, input reg_cap_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t ns: %s capability %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic ready_check(input logic [NREGS-1:0] got, input logic [NREGS-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t ns: ready vector %h, expected %h", $time, got, exp);
    end
  endtask

  task automatic credit_balance_check();
    check_cnt++;
    if (credits != int'(RVK_DEPTH) || credit_pulses != rvk_sent) begin
      err_cnt++;
      $display("ERR %0t ns: credits held %0d, pulses %0d for %0d revocations",
               $time, credits, credit_pulses, rvk_sent);
    end
  endtask

  // inputs change 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic write_entry(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                             input reg_cap_t cap);
    waddr = addr;
    wdata = data;
    wcap  = cap;
    we    = 1'b1;
    next_cycle();
    we = 1'b0;
  endtask

  task automatic read_entry(input logic [ADDR_W-1:0] addr, input rf_word_t exp_word,
                            input reg_cap_t exp_cap);
    raddr_a = addr;
    raddr_b = addr;
    @(negedge clk);
    word_check("port a word", rword_a, exp_word);
    word_check("port b word", rword_b, exp_word);
    cap_check("port a", rcap_a, exp_cap);
    cap_check("port b", rcap_b, exp_cap);
    next_cycle();
  endtask

  task automatic reserve_entry(input logic [ADDR_W-1:0] addr, input logic [NREGS-1:0] exp_rdy);
    trsv_addr  = addr;
    trsv_valid = 1'b1;
    next_cycle();
    trsv_valid = 1'b0;
    @(negedge clk);
    ready_check(reg_rdy, exp_rdy);
    next_cycle();
  endtask

  // a request goes out only while a credit is held
  task automatic revoke_entry(input logic [ADDR_W-1:0] addr, input logic clrtag);
    while (credits == 0) begin
      next_cycle();
    end
    rvk_addr   = addr;
    rvk_clrtag = clrtag;
    rvk_valid  = 1'b1;
    credits--;
    rvk_sent++;
    next_cycle();
    rvk_valid = 1'b0;
  endtask

  task automatic idle_cycles(input int cycles, input logic [NREGS-1:0] exp_rdy);
    repeat (cycles) next_cycle();
    @(negedge clk);
    ready_check(reg_rdy, exp_rdy);
    credit_balance_check();
    next_cycle();
  endtask

  // credit pulses and alert are sampled mid-cycle
  always @(negedge clk) begin
    if (par_rst_n) begin
      if (rvk_credit) begin
        credits++;
        credit_pulses++;
      end
      if (credits < 0 || credits > int'(RVK_DEPTH)) begin
        err_cnt++;
        $display("credit counter at %0d is outside 0 to %0d", credits, RVK_DEPTH);
      end
      if (alert && !alert_seen) begin
        alert_seen = 1'b1;
        err_cnt++;
        $display("alert raised at %0t ns on clean traffic", $time);
      end
    end
  end

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout, the run did not end within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  initial begin
    stim_rec_t rec;
    rf_word_t  exp_word;
    reg_cap_t  exp_cap;
    int        n;
    int        errs_before;
    raddr_a    = '0;
    raddr_b    = '0;
    waddr      = '0;
    wdata      = '0;
    wcap       = NULL_REG_CAP;
    we         = 1'b0;
    trsv_valid = 1'b0;
    trsv_addr  = '0;
    rvk_valid  = 1'b0;
    rvk_addr   = '0;
    rvk_clrtag = 1'b0;
    for (int i = 0; i < STIM_MAX; i++) begin
      stim_mem[i] = '0;
    end
    $readmemh("verification/cap_rf_stim.txt", stim_mem);
    n = 0;
    while (n < STIM_MAX && stim_mem[n][91:88] != OP_END) begin
      n++;
    end
    cycle_limit = 20 * n + 100;
    if (n == 0) begin
      err_cnt++;
      $display("stim file holds no commands");
    end

    wait (par_rst_n);
    next_cycle();
    for (int i = 0; i < n; i++) begin
      rec         = stim_mem[i];
      exp_word    = {rec.par[PAR_W-1:0], rec.arg};
      exp_cap     = rec.cap[CAP_W-1:0];
      errs_before = err_cnt;
      case (rec.op)
        OP_WRITE:   write_entry(rec.addr[ADDR_W-1:0], rec.arg, exp_cap);
        OP_READ:    read_entry(rec.addr[ADDR_W-1:0], exp_word, exp_cap);
        OP_RESERVE: reserve_entry(rec.addr[ADDR_W-1:0], rec.arg);
        OP_REVOKE:  revoke_entry(rec.addr[ADDR_W-1:0], rec.arg[0]);
        OP_IDLE:    idle_cycles(int'(rec.addr), rec.arg);
        default: begin
          err_cnt++;
          $display("stim line %0d holds an unknown command %h", i + 1, rec.op);
        end
      endcase
      test_cnt++;
      $display("test %0d %s entry %0h: %s", i + 1, op_name(rec.op), rec.addr,
               (err_cnt == errs_before) ? "ok" : "mismatch");
    end

    // let the queue drain before the closing balance
    repeat (3) next_cycle();
    @(negedge clk);
    credit_balance_check();
    $display("tests %0d, checks %0d, errors %0d, credit pulses %0d",
             test_cnt, check_cnt, err_cnt, credit_pulses);
    if (err_cnt == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ns
// -------------------------------------------------------------------------
// testbench clock and reset: 20 ns clock, reset held low for 5 cycles
// -------------------------------------------------------------------------
module tb_clk_gen (
  output logic clk_o,
  output logic rst_no
);

  // 10 ns half period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // release a little after the fifth rising edge
  initial begin
    rst_no = 1'b0;
    repeat (5) @(posedge clk_o);
    #2;
    rst_no = 1'b1;
  end

endmodule

//--- design/cap_rf_top.sv
`timescale 1ns/1ns
// -------------------------------------------------------------------------
// capability register file subsystem: request encoders, revocation queue
// and the register file behind the subsystem ports
// -------------------------------------------------------------------------
module cap_rf_top import cap_rf_pkg::*; (
  input  logic              clk_i,
  input  logic              par_rst_ni,
  input  logic [ADDR_W-1:0] raddr_a_i,
  input  logic [ADDR_W-1:0] raddr_b_i,
  output rf_word_t          rword_a_o,
  output rf_word_t          rword_b_o,
  output reg_cap_t          rcap_a_o,
  output reg_cap_t          rcap_b_o,
  input  logic [ADDR_W-1:0] waddr_i,
  input  logic [DATA_W-1:0] wdata_i,
  input  reg_cap_t          wcap_i,
  input  logic              we_i,
  input  logic              trsv_valid_i,
  input  logic [ADDR_W-1:0] trsv_addr_i,
  input  logic              rvk_valid_i,
  input  logic [ADDR_W-1:0] rvk_addr_i,
  input  logic              rvk_clrtag_i,
  output logic              rvk_credit_o,
  output logic [NREGS-1:0]  reg_rdy_o,
  output logic              alert_o
);

  logic [DATA_W-1:0] wreq_word, trsv_word, rvk_word;
  logic [PAR_W-1:0]  wpar, trsv_par, rvk_par;
  rf_word_t          wword;
  trsv_req_t         trsv_req;
  trvk_req_t         rvk_req, trvk_req;
  logic              trvk_en;

  // the write code covers address, enable, data and capability
  assign wreq_word = wreq_fold(waddr_i, we_i, wdata_i, wcap_i);
  assign trsv_word = rsv_payload(trsv_addr_i, trsv_valid_i);
  assign rvk_word  = rvk_payload(rvk_addr_i, rvk_clrtag_i);

  rf_secded_enc wword_enc_i (.data_i(wreq_word), .par_o(wpar));
  rf_secded_enc trsv_enc_i  (.data_i(trsv_word), .par_o(trsv_par));
  rf_secded_enc rvk_enc_i   (.data_i(rvk_word),  .par_o(rvk_par));

  assign wword    = '{par: wpar, data: wdata_i};
  assign trsv_req = '{addr: trsv_addr_i, en: trsv_valid_i, par: trsv_par};
  assign rvk_req  = '{addr: rvk_addr_i, clrtag: rvk_clrtag_i, par: rvk_par};

  rvk_req_queue rvk_queue_i (
    .clk_i      (clk_i),
    .par_rst_ni (par_rst_ni),
    .push_i     (rvk_valid_i),
    .req_i      (rvk_req),
    .issue_o    (trvk_en),
    .req_o      (trvk_req),
    .credit_o   (rvk_credit_o)
  );

  cap_regfile cap_regfile_i (
    .clk_i      (clk_i),
    .par_rst_ni (par_rst_ni),
    .raddr_a_i  (raddr_a_i),
    .raddr_b_i  (raddr_b_i),
    .rword_a_o  (rword_a_o),
    .rword_b_o  (rword_b_o),
    .rcap_a_o   (rcap_a_o),
    .rcap_b_o   (rcap_b_o),
    .waddr_i    (waddr_i),
    .wword_i    (wword),
    .wcap_i     (wcap_i),
    .we_i       (we_i),
    .trvk_en_i  (trvk_en),
    .trvk_i     (trvk_req),
    .trsv_i     (trsv_req),
    .reg_rdy_o  (reg_rdy_o),
    .alert_o    (alert_o)
  );

endmodule

//--- design/cap_regfile.sv
`timescale 1ns/1ns
// -------------------------------------------------------------------------
// capability register file: data words with check codes, capability tags,
// load ready vector with revocation bypass, and a registered fault alert
// -------------------------------------------------------------------------
module cap_regfile import cap_rf_pkg::*; (
  input  logic              clk_i,
  input  logic              par_rst_ni,
  input  logic [ADDR_W-1:0] raddr_a_i,
  input  logic [ADDR_W-1:0] raddr_b_i,
  output rf_word_t          rword_a_o,
  output rf_word_t          rword_b_o,
  output reg_cap_t          rcap_a_o,
  output reg_cap_t          rcap_b_o,
  input  logic [ADDR_W-1:0] waddr_i,
  input  rf_word_t          wword_i,
  input  reg_cap_t          wcap_i,
  input  logic              we_i,
  input  logic              trvk_en_i,
  input  trvk_req_t         trvk_i,
  input  trsv_req_t         trsv_i,
  output logic [NREGS-1:0]  reg_rdy_o,
  output logic              alert_o
);

  logic [DATA_W-1:0] data_q  [NREGS-1:1];
  logic [PAR_W-1:0]  par_q   [NREGS-1:1];
  reg_cap_t          cap_q   [NCAPS-1:1];
  logic [DATA_W-1:0] rf_data [NREGS];
  logic [PAR_W-1:0]  rf_par  [NREGS];
  reg_cap_t          rf_cap  [NCAPS];

  logic [NREGS-1:1]  we_dec, rvk_dec, rvk_clr_dec, rsv_dec;
  logic [NREGS-1:1]  rdy_q;

  always_comb begin
    for (int unsigned i = 1; i < NREGS; i++) begin
      we_dec[i]      = we_i && (waddr_i == ADDR_W'(i));
      rvk_dec[i]     = trvk_en_i && (trvk_i.addr == ADDR_W'(i));
      rvk_clr_dec[i] = rvk_dec[i] && trvk_i.clrtag;
      rsv_dec[i]     = trsv_i.en && (trsv_i.addr == ADDR_W'(i));
    end
  end

  // entry 0 has no storage
  for (genvar i = 1; i < NREGS; i++) begin : g_entry
    always_ff @(posedge clk_i or negedge par_rst_ni) begin
      if (!par_rst_ni) begin
        data_q[i] <= '0;
        par_q[i]  <= DEF_PAR_BITS[i];
      end else if (we_dec[i]) begin
        // a tag revoked in the same cycle still marks the new code
        data_q[i] <= wword_i.data;
        par_q[i]  <= rvk_clr_dec[i] ? (wword_i.par ^ TRVK_PAR_INCR) : wword_i.par;
      end else if (rvk_clr_dec[i]) begin
        par_q[i]  <= par_q[i] ^ TRVK_PAR_INCR;
      end
    end
  end

  for (genvar i = 1; i < NCAPS; i++) begin : g_cap
    always_ff @(posedge clk_i or negedge par_rst_ni) begin
      if (!par_rst_ni) begin
        cap_q[i] <= NULL_REG_CAP;
      end else begin
        if (we_dec[i]) begin
          cap_q[i] <= wcap_i;
        end
        // revocation comes from later in the pipeline and wins
        if (rvk_clr_dec[i]) begin
          cap_q[i].valid <= 1'b0;
        end
      end
    end
  end

  assign rf_data[0] = '0;
  assign rf_par[0]  = DEF_PAR_BITS[0];
  assign rf_cap[0]  = NULL_REG_CAP;
  for (genvar i = 1; i < NREGS; i++) begin : g_rd_data
    assign rf_data[i] = data_q[i];
    assign rf_par[i]  = par_q[i];
  end
  for (genvar i = 1; i < NCAPS; i++) begin : g_rd_cap
    assign rf_cap[i] = cap_q[i];
  end

  // ready vector, a reservation beats a revocation of the same entry
  always_ff @(posedge clk_i or negedge par_rst_ni) begin
    if (!par_rst_ni) begin
      rdy_q <= '1;
    end else begin
      for (int unsigned i = 1; i < NREGS; i++) begin
        if (rsv_dec[i]) begin
          rdy_q[i] <= 1'b0;
        end else if (rvk_dec[i]) begin
          rdy_q[i] <= 1'b1;
        end
      end
    end
  end

  // revocation shows up on the outputs in its issue cycle
  assign reg_rdy_o = {rdy_q | rvk_dec, 1'b1};
  assign rword_a_o = '{par: rf_par[raddr_a_i], data: rf_data[raddr_a_i]};
  assign rword_b_o = '{par: rf_par[raddr_b_i], data: rf_data[raddr_b_i]};

  always_comb begin
    rcap_a_o = rf_cap[raddr_a_i];
    rcap_b_o = rf_cap[raddr_b_i];
    if (trvk_en_i && trvk_i.clrtag && (trvk_i.addr == raddr_a_i)) begin
      rcap_a_o.valid = 1'b0;
    end
    if (trvk_en_i && trvk_i.clrtag && (trvk_i.addr == raddr_b_i)) begin
      rcap_b_o.valid = 1'b0;
    end
  end

  // fault checks on registered copies of every request
  trvk_req_t         trvk_q;
  trsv_req_t         trsv_q;
  logic              trvk_en_q;
  logic [NREGS-1:1]  rdy_real_q, rdy_shdw_q;
  logic [ADDR_W-1:0] waddr_q;
  logic              we_q;
  logic [DATA_W-1:0] wdata_q;
  logic [PAR_W-1:0]  wpar_q;
  reg_cap_t          wcap_q;
  logic              wrvk_hit_q;
  logic              alert_q;

  always_ff @(posedge clk_i or negedge par_rst_ni) begin
    if (!par_rst_ni) begin
      trvk_q     <= '{addr: '0, clrtag: 1'b0, par: NULL_PAR_BITS};
      trsv_q     <= '{addr: '0, en: 1'b0, par: NULL_PAR_BITS};
      trvk_en_q  <= 1'b0;
      rdy_real_q <= '1;
      waddr_q    <= '0;
      we_q       <= 1'b0;
      wdata_q    <= '0;
      wpar_q     <= NULL_PAR_BITS;
      wcap_q     <= NULL_REG_CAP;
      wrvk_hit_q <= 1'b0;
    end else begin
      trvk_q     <= trvk_i;
      trsv_q     <= trsv_i;
      trvk_en_q  <= trvk_en_i;
      rdy_real_q <= rdy_q;
      waddr_q    <= waddr_i;
      we_q       <= we_i;
      wdata_q    <= wword_i.data;
      wpar_q     <= wword_i.par;
      wcap_q     <= wcap_i;
      wrvk_hit_q <= trvk_en_i && trvk_i.clrtag && (trvk_i.addr == waddr_i);
    end
  end

  // shadow ready vector runs one cycle behind the real one
  always_ff @(posedge clk_i or negedge par_rst_ni) begin
    if (!par_rst_ni) begin
      rdy_shdw_q <= '1;
    end else begin
      for (int unsigned i = 1; i < NREGS; i++) begin
        if (trsv_q.en && (trsv_q.addr == ADDR_W'(i))) begin
          rdy_shdw_q[i] <= 1'b0;
        end else if (trvk_en_q && (trvk_q.addr == ADDR_W'(i))) begin
          rdy_shdw_q[i] <= 1'b1;
        end
      end
    end
  end

  rf_word_t   trsv_cw, trvk_cw, wreq_cw;
  logic [1:0] trsv_err, trvk_err, wreq_err;
  logic       shdw_err, rvk_err, rdbk_err;

  assign trsv_cw = '{par: trsv_q.par, data: rsv_payload(trsv_q.addr, trsv_q.en)};
  assign trvk_cw = '{par: trvk_q.par, data: rvk_payload(trvk_q.addr, trvk_q.clrtag)};
  assign wreq_cw = '{par: wpar_q, data: wreq_fold(waddr_q, we_q, wdata_q, wcap_q)};

  rf_secded_dec trsv_dec_i (.word_i(trsv_cw), .err_o(trsv_err));
  rf_secded_dec trvk_dec_i (.word_i(trvk_cw), .err_o(trvk_err));
  rf_secded_dec wreq_dec_i (.word_i(wreq_cw), .err_o(wreq_err));

  assign shdw_err = (rdy_shdw_q != rdy_real_q);
  // a revoked tag must read back cleared
  assign rvk_err  = trvk_en_q && trvk_q.clrtag && rf_cap[trvk_q.addr].valid;
  assign rdbk_err = we_q && (waddr_q != '0) &&
                    (rf_par[waddr_q] != (wpar_q ^ (wrvk_hit_q ? TRVK_PAR_INCR : '0)));

  always_ff @(posedge clk_i or negedge par_rst_ni) begin
    if (!par_rst_ni) begin
      alert_q <= 1'b0;
    end else begin
      alert_q <= shdw_err | rvk_err | (|trsv_err) | (trvk_en_q & (|trvk_err)) |
                 (|wreq_err) | rdbk_err;
    end
  end

  assign alert_o = alert_q;

  // a write to entry 0 leaves every stored word as it was
  for (genvar i = 1; i < NREGS; i++) begin : g_entry0_chk
    a_entry0_fixed: assert property (@(posedge clk_i) disable iff (!par_rst_ni)
      (we_i && (waddr_i == '0)) |=> $stable(data_q[i]));
  end

endmodule

//--- design/rvk_req_queue.sv
`timescale 1ns/1ns
// -------------------------------------------------------------------------
// revocation request queue: credit-controlled FIFO that issues its head
// request every cycle it holds one and returns a credit for each issue
// -------------------------------------------------------------------------
module rvk_req_queue import cap_rf_pkg::*; (
  input  logic      clk_i,
  input  logic      par_rst_ni,
  input  logic      push_i,
  input  trvk_req_t req_i,
  output logic      issue_o,
  output trvk_req_t req_o,
  output logic      credit_o
);

  trvk_req_t            mem_q [RVK_DEPTH];
  logic [RVK_PTR_W-1:0] wr_ptr_q;
  logic [RVK_PTR_W-1:0] rd_ptr_q;
  logic [RVK_CNT_W-1:0] count_q;
  logic                 full;

  assign full    = (count_q == RVK_CNT_W'(RVK_DEPTH));
  assign issue_o = (count_q != '0);
  assign req_o   = mem_q[rd_ptr_q];

  // one credit goes back in the cycle the request leaves
  assign credit_o = issue_o;

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= req_i;
    end
  end

  // pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk_i or negedge par_rst_ni) begin
    if (!par_rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (issue_o) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, issue_o})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // the sender spends a credit per push, so a full queue only takes a
  // push in a cycle that also frees a slot
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!par_rst_ni)
    !(push_i && full && !issue_o));

endmodule

//--- design/rf_secded_dec.sv
`timescale 1ns/1ns
// -------------------------------------------------------------------------
// check code decoder: recomputes the syndrome of a 39-bit codeword and
// flags single and double errors, no correction
// -------------------------------------------------------------------------
module rf_secded_dec import cap_rf_pkg::*; (
  input  rf_word_t   word_i,
  output logic [1:0] err_o
);

  logic [PAR_W-1:0] syndrome;
  logic             syn_odd;

  // syndrome is zero for a clean codeword
  always_comb begin
    for (int unsigned k = 0; k < PAR_W; k++) begin
      syndrome[k] = ^(word_i.data & SECDED_MASK[k]) ^ word_i.par[k] ^ PAR_INV[k];
    end
  end

  // every column has odd weight, so an odd syndrome means one flipped bit
  assign syn_odd = ^syndrome;

  // bit 0 single error, bit 1 double error
  assign err_o[0] = syn_odd;
  assign err_o[1] = !syn_odd && (|syndrome);

endmodule

//--- design/rf_secded_enc.sv
`timescale 1ns/1ns
// -------------------------------------------------------------------------
// check code encoder: 7 inverted hamming check bits over a 32-bit word
// -------------------------------------------------------------------------
module rf_secded_enc import cap_rf_pkg::*; (
  input  logic [DATA_W-1:0] data_i,
  output logic [PAR_W-1:0]  par_o
);

  logic [PAR_W-1:0] par_raw;

  // each check bit is the parity of the data bits in its mask
  always_comb begin
    for (int unsigned k = 0; k < PAR_W; k++) begin
      par_raw[k] = ^(data_i & SECDED_MASK[k]);
    end
  end

  // inversion keeps an all-zero codeword from being valid
  assign par_o = par_raw ^ PAR_INV;

endmodule

//--- design/cap_rf_pkg.sv
// -------------------------------------------------------------------------
// capability register file package: sizes, check code constants,
// capability and request structs, and the request packing functions
// -------------------------------------------------------------------------
package cap_rf_pkg;

  localparam int unsigned NREGS     = 32;
  localparam int unsigned NCAPS     = 32;
  localparam int unsigned ADDR_W    = 5;
  localparam int unsigned DATA_W    = 32;
  localparam int unsigned CAP_W     = 38;
  localparam int unsigned PAR_W     = 7;
  localparam int unsigned RVK_DEPTH = 4;
  localparam int unsigned RVK_PTR_W = 2;
  localparam int unsigned RVK_CNT_W = 3;

  // inverted hamming code, check bits 1, 3 and 5 are flipped
  localparam logic [PAR_W-1:0] PAR_INV       = 7'h2a;
  // check code of an all-zero word
  localparam logic [PAR_W-1:0] NULL_PAR_BITS = PAR_INV;
  localparam logic [PAR_W-1:0] TRVK_PAR_INCR = 7'h15;

  // data bits covered by each check bit
  localparam logic [DATA_W-1:0] SECDED_MASK [PAR_W] = '{
    32'h2606bd25, 32'hdeba8050, 32'h413d89aa, 32'h31234ed1,
    32'hc2c1323b, 32'h2dcc624c, 32'h98505586
  };

  // per-entry codes after reset, entry 0 holds the code of zero data
  localparam logic [PAR_W-1:0] DEF_PAR_BITS [NREGS] = '{
    7'h2a, 7'h13, 7'h4c, 7'h75, 7'h06, 7'h3f, 7'h60, 7'h59,
    7'h1b, 7'h22, 7'h7d, 7'h44, 7'h37, 7'h0e, 7'h51, 7'h68,
    7'h0b, 7'h32, 7'h6d, 7'h54, 7'h27, 7'h1e, 7'h41, 7'h78,
    7'h3a, 7'h03, 7'h5c, 7'h65, 7'h16, 7'h2f, 7'h70, 7'h49
  };

  typedef struct packed {
    logic        valid;
    logic [11:0] perms;
    logic [3:0]  otype;
    logic [4:0]  exp;
    logic [7:0]  top;
    logic [7:0]  base;
  } reg_cap_t;

  localparam reg_cap_t NULL_REG_CAP = '0;

  typedef struct packed {
    logic [PAR_W-1:0]  par;
    logic [DATA_W-1:0] data;
  } rf_word_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              clrtag;
    logic [PAR_W-1:0]  par;
  } trvk_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              en;
    logic [PAR_W-1:0]  par;
  } trsv_req_t;

  function automatic logic [CAP_W-1:0] reg2vec(reg_cap_t cap);
    return {cap.valid, cap.perms, cap.otype, cap.exp, cap.top, cap.base};
  endfunction

  // whole write request folded into one word, one code covers all of it
  function automatic logic [DATA_W-1:0] wreq_fold(logic [ADDR_W-1:0] addr, logic we,
                                                  logic [DATA_W-1:0] data, reg_cap_t cap);
    logic [CAP_W-1:0] vec;
    vec = reg2vec(cap);
    return data ^ vec[DATA_W-1:0] ^
           {{(2*DATA_W-CAP_W-ADDR_W-1){1'b0}}, we, addr, vec[CAP_W-1:DATA_W]};
  endfunction

  function automatic logic [DATA_W-1:0] rsv_payload(logic [ADDR_W-1:0] addr, logic en);
    return {{(DATA_W-ADDR_W-1){1'b0}}, en, addr};
  endfunction

  function automatic logic [DATA_W-1:0] rvk_payload(logic [ADDR_W-1:0] addr, logic clrtag);
    return {{(DATA_W-ADDR_W-1){1'b0}}, clrtag, addr};
  endfunction

endpackage
